// ==== design/cc_pkg.sv ====
// ---------------------------------------------------------------------
// Shared widths and stream payloads of the core complex interconnect
// NumAcc must be a power of two and match AccSelWidth
// ---------------------------------------------------------------------

package cc_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 5;

  // Offload fan-out, selected by the low address bits
  localparam int unsigned NumAcc      = 4;
  localparam int unsigned AccSelWidth = 2;

  // Requesters sharing the data bus (integer core, FP subsystem)
  localparam int unsigned NumReq = 2;

  // ---------------------------------------------------------------------
  // Offload payloads
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [IdWidth-1:0]   id;
    logic [31:0]          data_op;
    logic [DataWidth-1:0] data_arga;
  } acc_req_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } acc_rsp_t;

  // ---------------------------------------------------------------------
  // Data memory payloads
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
    logic [3:0]           strb;
    logic                 write;
  } dreq_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 error;
  } drsp_t;

endpackage

// ==== design/offload_demux.sv ====
// ---------------------------------------------------------------------
// Offload request steering, purely combinational
// Port is chosen by the low AccSelWidth bits of the request address
// Select values without a port are never acknowledged
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module offload_demux #(
  parameter int unsigned NumOut = 4
) (
  // Request from the integer core
  input  cc_pkg::acc_req_t    acc_req_i,
  input  logic                acc_qvalid_i,
  output logic                acc_qready_o,
  // Shared payload, one valid per accelerator
  output cc_pkg::acc_req_t    acc_req_o,
  output logic [NumOut-1:0]   acc_qvalid_o,
  input  logic [NumOut-1:0]   acc_qready_i
);

  logic [cc_pkg::AccSelWidth-1:0] sel;

  // Select field sits in the lowest address bits
  assign sel = acc_req_i.addr[cc_pkg::AccSelWidth-1:0];

  // All accelerators see the same payload, only valid is steered
  assign acc_req_o = acc_req_i;

  always_comb begin
    acc_qvalid_o = '0;
    acc_qready_o = 1'b0;
    for (int unsigned k = 0; k < NumOut; k++) begin
      if (sel == cc_pkg::AccSelWidth'(k)) begin
        acc_qvalid_o[k] = acc_qvalid_i;
        acc_qready_o    = acc_qready_i[k];
      end
    end
  end

endmodule

// ==== design/rr_arbiter.sv ====
// ---------------------------------------------------------------------
// Round-robin valid/ready arbiter with a generic payload type
// Grant is combinational and held while the output is stalled
// Inputs must keep valid high until their transfer
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module rr_arbiter #(
  parameter int unsigned NumInp = 2,
  parameter type         payload_t = logic,
  localparam int unsigned IdxWidth = (NumInp > 1) ? $clog2(NumInp) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Competing input streams
  input  payload_t [NumInp-1:0]    inp_data_i,
  input  logic [NumInp-1:0]        inp_valid_i,
  output logic [NumInp-1:0]        inp_ready_o,
  // Merged output stream
  output payload_t                 oup_data_o,
  output logic                     oup_valid_o,
  input  logic                     oup_ready_i,
  output logic [IdxWidth-1:0]      oup_idx_o
);

  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] lock_idx_q;
  logic                lock_q;
  logic [IdxWidth-1:0] sel_idx;
  logic [IdxWidth-1:0] gnt_idx;
  logic                found;

  // ---------------------------------------------------------------------
  // First valid input at or after the pointer, wrapping around
  // ---------------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    found   = 1'b0;
    sel_idx = ptr_q;
    for (int unsigned i = 0; i < NumInp; i++) begin
      cand = (ptr_q + i) % NumInp;
      if (!found && inp_valid_i[cand]) begin
        found   = 1'b1;
        sel_idx = IdxWidth'(cand);
      end
    end
  end

  // A stalled grant stays put so the payload cannot change under it
  assign gnt_idx     = lock_q ? lock_idx_q : sel_idx;
  assign oup_idx_o   = gnt_idx;
  assign oup_valid_o = lock_q ? inp_valid_i[gnt_idx] : found;
  assign oup_data_o  = inp_data_i[gnt_idx];

  always_comb begin
    inp_ready_o          = '0;
    inp_ready_o[gnt_idx] = oup_ready_i;
  end

  // ---------------------------------------------------------------------
  // Pointer and lock
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (oup_valid_o && oup_ready_i) begin
      // Next search starts one past the winner
      ptr_q  <= (gnt_idx == IdxWidth'(NumInp - 1)) ? '0 : gnt_idx + 1'b1;
      lock_q <= 1'b0;
    end else if (oup_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

// ==== design/data_router.sv ====
// ---------------------------------------------------------------------
// Address decode to TCDM or SoC with in-order response return
// Up to RespDepth requests in flight; AliasStart must be aligned to
// 2**TcdmAddrWidth. Targets must answer in their own issue order
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module data_router #(
  parameter int unsigned                    RespDepth     = 4,
  parameter int unsigned                    TcdmAddrWidth = 12,
  parameter bit                             AliasEnable   = 1'b1,
  parameter logic [cc_pkg::AddrWidth-1:0]   AliasStart    = 32'h1000_0000,
  localparam int unsigned ReqIdxWidth = (cc_pkg::NumReq > 1) ? $clog2(cc_pkg::NumReq) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [cc_pkg::AddrWidth-1:0]   tcdm_base_i,
  // Merged request from the arbiter
  input  cc_pkg::dreq_t                  req_i,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic [ReqIdxWidth-1:0]         req_idx_i,
  // TCDM target
  output cc_pkg::dreq_t                  tcdm_req_o,
  output logic                           tcdm_valid_o,
  input  logic                           tcdm_ready_i,
  input  cc_pkg::drsp_t                  tcdm_rsp_i,
  input  logic                           tcdm_rsp_valid_i,
  output logic                           tcdm_rsp_ready_o,
  // SoC target
  output cc_pkg::dreq_t                  soc_req_o,
  output logic                           soc_valid_o,
  input  logic                           soc_ready_i,
  input  cc_pkg::drsp_t                  soc_rsp_i,
  input  logic                           soc_rsp_valid_i,
  output logic                           soc_rsp_ready_o,
  // Responses back to the requesters
  output cc_pkg::drsp_t                  drsp_o,
  output logic [cc_pkg::NumReq-1:0]      drsp_valid_o,
  input  logic [cc_pkg::NumReq-1:0]      drsp_ready_i
);

  localparam int unsigned PtrWidth = (RespDepth > 1) ? $clog2(RespDepth) : 1;
  localparam int unsigned CntWidth = $clog2(RespDepth + 1);
  localparam int unsigned Hi       = cc_pkg::AddrWidth - 1;

  // Who asked, and which target will answer
  typedef struct packed {
    logic [ReqIdxWidth-1:0] idx;
    logic                   tcdm;
  } ord_t;

  ord_t                fifo_q [RespDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                full;
  logic                empty;
  logic                hit_base;
  logic                hit_alias;
  logic                to_tcdm;
  logic                push;
  logic                pop;
  ord_t                head;
  logic                rsp_valid;
  logic                rsp_ready;

  // ---------------------------------------------------------------------
  // Address decode
  // ---------------------------------------------------------------------
  assign hit_base  = req_i.addr[Hi:TcdmAddrWidth] == tcdm_base_i[Hi:TcdmAddrWidth];
  assign hit_alias = AliasEnable && (req_i.addr[Hi:TcdmAddrWidth] == AliasStart[Hi:TcdmAddrWidth]);
  assign to_tcdm   = hit_base || hit_alias;

  assign full  = (cnt_q == CntWidth'(RespDepth));
  assign empty = (cnt_q == '0);

  // Request passes straight through while there is room to track it
  assign tcdm_req_o   = req_i;
  assign soc_req_o    = req_i;
  assign tcdm_valid_o = req_valid_i && !full && to_tcdm;
  assign soc_valid_o  = req_valid_i && !full && !to_tcdm;
  assign req_ready_o  = !full && (to_tcdm ? tcdm_ready_i : soc_ready_i);
  assign push         = req_valid_i && req_ready_o;

  // ---------------------------------------------------------------------
  // Response return, only from the target at the FIFO head
  // ---------------------------------------------------------------------
  assign head      = fifo_q[rd_ptr_q];
  assign rsp_valid = !empty && (head.tcdm ? tcdm_rsp_valid_i : soc_rsp_valid_i);
  assign rsp_ready = drsp_ready_i[head.idx];
  assign drsp_o    = head.tcdm ? tcdm_rsp_i : soc_rsp_i;
  assign pop       = rsp_valid && rsp_ready;

  assign tcdm_rsp_ready_o = !empty && head.tcdm && rsp_ready;
  assign soc_rsp_ready_o  = !empty && !head.tcdm && rsp_ready;

  always_comb begin
    drsp_valid_o           = '0;
    drsp_valid_o[head.idx] = rsp_valid;
  end

  // ---------------------------------------------------------------------
  // Order FIFO
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{idx: req_idx_i, tcdm: to_tcdm};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(RespDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(RespDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy changes only when one side moves alone
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// ==== design/core_complex.sv ====
// ---------------------------------------------------------------------
// Offload and data-memory interconnect of the core complex
// Offload requests fan out to NumAcc accelerators; two requesters
// share one data bus decoded to TCDM or SoC
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module core_complex #(
  parameter int unsigned                    RespDepth     = 4,
  parameter int unsigned                    TcdmAddrWidth = 12,
  parameter bit                             AliasEnable   = 1'b1,
  parameter logic [cc_pkg::AddrWidth-1:0]   AliasStart    = 32'h1000_0000
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [cc_pkg::AddrWidth-1:0]             tcdm_base_i,
  // Offload request from the core
  input  cc_pkg::acc_req_t                         acc_req_i,
  input  logic                                     acc_qvalid_i,
  output logic                                     acc_qready_o,
  // Offload requests to the accelerators
  output cc_pkg::acc_req_t                         acc_req_o,
  output logic [cc_pkg::NumAcc-1:0]                acc_qvalid_o,
  input  logic [cc_pkg::NumAcc-1:0]                acc_qready_i,
  // Accelerator responses
  input  cc_pkg::acc_rsp_t [cc_pkg::NumAcc-1:0]    acc_rsp_i,
  input  logic [cc_pkg::NumAcc-1:0]                acc_pvalid_i,
  output logic [cc_pkg::NumAcc-1:0]                acc_pready_o,
  // Merged response to the core
  output cc_pkg::acc_rsp_t                         acc_rsp_o,
  output logic                                     acc_pvalid_o,
  input  logic                                     acc_pready_i,
  // Data requesters
  input  cc_pkg::dreq_t [cc_pkg::NumReq-1:0]       dreq_i,
  input  logic [cc_pkg::NumReq-1:0]                dreq_valid_i,
  output logic [cc_pkg::NumReq-1:0]                dreq_ready_o,
  output cc_pkg::drsp_t                            drsp_o,
  output logic [cc_pkg::NumReq-1:0]                drsp_valid_o,
  input  logic [cc_pkg::NumReq-1:0]                drsp_ready_i,
  // TCDM port
  output cc_pkg::dreq_t                            tcdm_req_o,
  output logic                                     tcdm_valid_o,
  input  logic                                     tcdm_ready_i,
  input  cc_pkg::drsp_t                            tcdm_rsp_i,
  input  logic                                     tcdm_rsp_valid_i,
  output logic                                     tcdm_rsp_ready_o,
  // SoC port
  output cc_pkg::dreq_t                            soc_req_o,
  output logic                                     soc_valid_o,
  input  logic                                     soc_ready_i,
  input  cc_pkg::drsp_t                            soc_rsp_i,
  input  logic                                     soc_rsp_valid_i,
  output logic                                     soc_rsp_ready_o
);

  localparam int unsigned ReqIdxWidth = (cc_pkg::NumReq > 1) ? $clog2(cc_pkg::NumReq) : 1;

  cc_pkg::dreq_t          merged_req;
  logic                   merged_valid;
  logic                   merged_ready;
  logic [ReqIdxWidth-1:0] merged_idx;

  // ---------------------------------------------------------------------
  // Offload path
  // ---------------------------------------------------------------------
  offload_demux #(
    .NumOut (cc_pkg::NumAcc)
  ) u_offload_demux (
    .acc_req_i    (acc_req_i),
    .acc_qvalid_i (acc_qvalid_i),
    .acc_qready_o (acc_qready_o),
    .acc_req_o    (acc_req_o),
    .acc_qvalid_o (acc_qvalid_o),
    .acc_qready_i (acc_qready_i)
  );

  // Response ids identify the source, so the index stays open
  rr_arbiter #(
    .NumInp    (cc_pkg::NumAcc),
    .payload_t (cc_pkg::acc_rsp_t)
  ) u_acc_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inp_data_i  (acc_rsp_i),
    .inp_valid_i (acc_pvalid_i),
    .inp_ready_o (acc_pready_o),
    .oup_data_o  (acc_rsp_o),
    .oup_valid_o (acc_pvalid_o),
    .oup_ready_i (acc_pready_i),
    .oup_idx_o   ()
  );

  // ---------------------------------------------------------------------
  // Data path
  // ---------------------------------------------------------------------
  rr_arbiter #(
    .NumInp    (cc_pkg::NumReq),
    .payload_t (cc_pkg::dreq_t)
  ) u_data_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inp_data_i  (dreq_i),
    .inp_valid_i (dreq_valid_i),
    .inp_ready_o (dreq_ready_o),
    .oup_data_o  (merged_req),
    .oup_valid_o (merged_valid),
    .oup_ready_i (merged_ready),
    .oup_idx_o   (merged_idx)
  );

  data_router #(
    .RespDepth     (RespDepth),
    .TcdmAddrWidth (TcdmAddrWidth),
    .AliasEnable   (AliasEnable),
    .AliasStart    (AliasStart)
  ) u_data_router (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tcdm_base_i      (tcdm_base_i),
    .req_i            (merged_req),
    .req_valid_i      (merged_valid),
    .req_ready_o      (merged_ready),
    .req_idx_i        (merged_idx),
    .tcdm_req_o       (tcdm_req_o),
    .tcdm_valid_o     (tcdm_valid_o),
    .tcdm_ready_i     (tcdm_ready_i),
    .tcdm_rsp_i       (tcdm_rsp_i),
    .tcdm_rsp_valid_i (tcdm_rsp_valid_i),
    .tcdm_rsp_ready_o (tcdm_rsp_ready_o),
    .soc_req_o        (soc_req_o),
    .soc_valid_o      (soc_valid_o),
    .soc_ready_i      (soc_ready_i),
    .soc_rsp_i        (soc_rsp_i),
    .soc_rsp_valid_i  (soc_rsp_valid_i),
    .soc_rsp_ready_o  (soc_rsp_ready_o),
    .drsp_o           (drsp_o),
    .drsp_valid_o     (drsp_valid_o),
    .drsp_ready_i     (drsp_ready_i)
  );

endmodule

// ==== bench/cc_sva.sv ====
// ---------------------------------------------------------------------
// Handshake properties of the core complex top level
// Checked only outside reset
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module cc_sva (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic [cc_pkg::NumAcc-1:0] acc_qvalid_o,
  input cc_pkg::acc_rsp_t          acc_rsp_o,
  input logic                      acc_pvalid_o,
  input logic                      acc_pready_i,
  input logic [cc_pkg::NumReq-1:0] drsp_valid_o
);

  int unsigned fail_cnt = 0;

  // One accelerator addressed at a time
  qvalid_onehot: assert property (@(posedge clk_i) disable iff (rst_ni)
    $onehot0(acc_qvalid_o))
    else begin
      $error("more than one acc_qvalid_o bit high");
      fail_cnt++;
    end

  // Stalled response keeps valid and payload
  prsp_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
    acc_pvalid_o && !acc_pready_i |=> acc_pvalid_o && $stable(acc_rsp_o))
    else begin
      $error("acc_pvalid_o or acc_rsp_o changed while stalled");
      fail_cnt++;
    end

  // Responses go to a single requester
  drsp_onehot: assert property (@(posedge clk_i) disable iff (rst_ni)
    $onehot0(drsp_valid_o))
    else begin
      $error("more than one drsp_valid_o bit high");
      fail_cnt++;
    end

endmodule

bind core_complex cc_sva u_cc_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .acc_qvalid_o (acc_qvalid_o),
  .acc_rsp_o    (acc_rsp_o),
  .acc_pvalid_o (acc_pvalid_o),
  .acc_pready_i (acc_pready_i),
  .drsp_valid_o (drsp_valid_o)
);

// ==== bench/tb_core_complex.sv ====
// ---------------------------------------------------------------------
// Directed tests of the core complex interconnect
// Memory models answer with the address XOR a per-target key
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module tb_core_complex;

  localparam int unsigned RespDepth = 4;
  localparam int          Timeout   = 200;
  localparam logic [31:0] TcdmBase  = 32'h8000_0000;
  localparam logic [31:0] SocBase   = 32'h4000_0000;
  localparam logic [31:0] AliasBase = 32'h1000_0000;
  localparam logic [31:0] TcdmKey   = 32'h5a5a_0000;
  localparam logic [31:0] SocKey    = 32'h0000_a5a5;

  logic                                  clk_i = 1'b0;
  logic                                  rst_ni;
  logic [cc_pkg::AddrWidth-1:0]          tcdm_base_i;
  cc_pkg::acc_req_t                      acc_req_i;
  logic                                  acc_qvalid_i;
  logic                                  acc_qready_o;
  cc_pkg::acc_req_t                      acc_req_o;
  logic [cc_pkg::NumAcc-1:0]             acc_qvalid_o;
  logic [cc_pkg::NumAcc-1:0]             acc_qready_i;
  cc_pkg::acc_rsp_t [cc_pkg::NumAcc-1:0] acc_rsp_i;
  logic [cc_pkg::NumAcc-1:0]             acc_pvalid_i;
  logic [cc_pkg::NumAcc-1:0]             acc_pready_o;
  cc_pkg::acc_rsp_t                      acc_rsp_o;
  logic                                  acc_pvalid_o;
  logic                                  acc_pready_i;
  cc_pkg::dreq_t [cc_pkg::NumReq-1:0]    dreq_i;
  logic [cc_pkg::NumReq-1:0]             dreq_valid_i;
  logic [cc_pkg::NumReq-1:0]             dreq_ready_o;
  cc_pkg::drsp_t                         drsp_o;
  logic [cc_pkg::NumReq-1:0]             drsp_valid_o;
  logic [cc_pkg::NumReq-1:0]             drsp_ready_i;
  cc_pkg::dreq_t                         tcdm_req_o;
  logic                                  tcdm_valid_o;
  logic                                  tcdm_ready_i;
  cc_pkg::drsp_t                         tcdm_rsp_i;
  logic                                  tcdm_rsp_valid_i;
  logic                                  tcdm_rsp_ready_o;
  cc_pkg::dreq_t                         soc_req_o;
  logic                                  soc_valid_o;
  logic                                  soc_ready_i;
  cc_pkg::drsp_t                         soc_rsp_i;
  logic                                  soc_rsp_valid_i;
  logic                                  soc_rsp_ready_o;

  logic                                  mem_respond;
  cc_pkg::drsp_t                         exp_q [cc_pkg::NumReq][$];
  int unsigned                           rsp_count = 0;

  always #10 clk_i = ~clk_i;

  core_complex #(
    .RespDepth     (RespDepth),
    .TcdmAddrWidth (12),
    .AliasEnable   (1'b1),
    .AliasStart    (AliasBase)
  ) u_dut (.*);

  mem_model #(.Key(TcdmKey)) u_tcdm_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .respond_i   (mem_respond),
    .req_valid_i (tcdm_valid_o),
    .req_ready_i (tcdm_ready_i),
    .req_i       (tcdm_req_o),
    .rsp_o       (tcdm_rsp_i),
    .rsp_valid_o (tcdm_rsp_valid_i),
    .rsp_ready_i (tcdm_rsp_ready_o)
  );

  mem_model #(.Key(SocKey)) u_soc_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .respond_i   (mem_respond),
    .req_valid_i (soc_valid_o),
    .req_ready_i (soc_ready_i),
    .req_i       (soc_req_o),
    .rsp_o       (soc_rsp_i),
    .rsp_valid_o (soc_rsp_valid_i),
    .rsp_ready_i (soc_rsp_ready_o)
  );

  // ---------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ---------------------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_acc_req(input string name, input cc_pkg::acc_req_t got,
                               input cc_pkg::acc_req_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_acc_rsp(input string name, input cc_pkg::acc_rsp_t got,
                               input cc_pkg::acc_rsp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_dreq(input string name, input cc_pkg::dreq_t got,
                            input cc_pkg::dreq_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_drsp(input string name, input cc_pkg::drsp_t got,
                            input cc_pkg::drsp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Valid and ready vectors
  task automatic check_flags(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Every data response transfer is checked against its requester's queue
  always @(posedge clk_i) begin
    for (int r = 0; r < cc_pkg::NumReq; r++) begin
      if (!rst_ni && drsp_valid_o[r] && drsp_ready_i[r]) begin
        rsp_count++;
        if (exp_q[r].size() == 0) begin
          report_failure($sformatf("Requester %0d got a response it never asked for", r));
        end else begin
          check_drsp($sformatf("drsp_o (requester %0d)", r), drsp_o, exp_q[r].pop_front());
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------
  task automatic reset_dut();
    rst_ni = 1'b1;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b0;
  endtask

  task automatic wait_accept(input int r);
    int cyc;
    for (cyc = 0; cyc < Timeout; cyc++) begin
      @(posedge clk_i);
      if (dreq_ready_o[r]) break;
    end
    if (cyc == Timeout) begin
      report_failure($sformatf("Timeout: request of requester %0d never accepted", r));
    end
  endtask

  task automatic wait_drain();
    int cyc;
    for (cyc = 0; cyc < Timeout; cyc++) begin
      if (exp_q[0].size() == 0 && exp_q[1].size() == 0) break;
      @(negedge clk_i);
    end
    if (cyc == Timeout) report_failure("Timeout: data responses still outstanding");
  endtask

  // One read, expected data follows the target the address should hit
  task automatic send_req(input int r, input logic [31:0] addr, input bit to_tcdm,
                          input bit check_route);
    cc_pkg::dreq_t req;
    cc_pkg::drsp_t exp;
    req.addr  = addr;
    req.data  = $urandom;
    req.strb  = 4'hf;
    req.write = 1'b0;
    exp.data  = addr ^ (to_tcdm ? TcdmKey : SocKey);
    exp.error = 1'b0;
    exp_q[r].push_back(exp);
    @(negedge clk_i);
    dreq_i[r]       = req;
    dreq_valid_i[r] = 1'b1;
    if (check_route) begin
      #1;
      check_flags("tcdm_valid_o", tcdm_valid_o, to_tcdm);
      check_flags("soc_valid_o", soc_valid_o, !to_tcdm);
      if (to_tcdm) check_dreq("tcdm_req_o", tcdm_req_o, req);
      else check_dreq("soc_req_o", soc_req_o, req);
    end
    wait_accept(r);
    @(negedge clk_i);
    dreq_valid_i[r] = 1'b0;
  endtask

  task automatic run_requester(input int r);
    bit          to_tcdm;
    logic [31:0] addr;
    for (int i = 0; i < 8; i++) begin
      to_tcdm = $urandom_range(1);
      addr    = to_tcdm ? (TcdmBase | ($urandom & 32'hffc)) : (SocBase | ($urandom & 32'hfffc));
      send_req(r, addr, to_tcdm, 1'b0);
    end
  endtask

  // Accept the response of accelerator k after one stalled cycle
  task automatic take_acc_rsp(input int k, input cc_pkg::acc_rsp_t exp);
    #1;
    check_flags("acc_pvalid_o", acc_pvalid_o, 1);
    check_acc_rsp("acc_rsp_o", acc_rsp_o, exp);
    @(negedge clk_i);
    acc_pready_i = 1'b1;
    #1;
    check_acc_rsp("acc_rsp_o", acc_rsp_o, exp);
    check_flags("acc_pready_o", acc_pready_o, 32'(1) << k);
    @(negedge clk_i);
    acc_pvalid_i[k] = 1'b0;
    acc_pready_i    = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------
  task automatic test_offload_route();
    cc_pkg::acc_req_t req;
    for (int k = 0; k < cc_pkg::NumAcc; k++) begin
      req.addr      = $urandom;
      req.addr[cc_pkg::AccSelWidth-1:0] = cc_pkg::AccSelWidth'(k);
      req.id        = $urandom;
      req.data_op   = $urandom;
      req.data_arga = $urandom;
      @(negedge clk_i);
      acc_req_i    = req;
      acc_qvalid_i = 1'b1;
      // Ready of the other ports must not leak through
      acc_qready_i = ~(cc_pkg::NumAcc'(1) << k);
      #1;
      check_acc_req("acc_req_o", acc_req_o, req);
      check_flags("acc_qvalid_o", acc_qvalid_o, 32'(1) << k);
      check_flags("acc_qready_o", acc_qready_o, 0);
      @(negedge clk_i);
      acc_qready_i = cc_pkg::NumAcc'(1) << k;
      #1;
      check_flags("acc_qready_o", acc_qready_o, 1);
    end
    @(negedge clk_i);
    acc_qvalid_i = 1'b0;
    acc_qready_i = '0;
  endtask

  task automatic test_acc_arbitration();
    cc_pkg::acc_rsp_t rsp [cc_pkg::NumAcc];
    for (int k = 0; k < cc_pkg::NumAcc; k++) begin
      rsp[k].id    = cc_pkg::IdWidth'(k);
      rsp[k].data  = $urandom;
      rsp[k].error = 1'b0;
    end
    @(negedge clk_i);
    for (int k = 0; k < cc_pkg::NumAcc; k++) acc_rsp_i[k] = rsp[k];
    acc_pvalid_i = '1;
    acc_pready_i = 1'b0;
    // Pointer is 0 after reset and moves one past each winner
    for (int n = 0; n < cc_pkg::NumAcc; n++) begin
      take_acc_rsp(n, rsp[n]);
    end
    #1;
    check_flags("acc_pvalid_o", acc_pvalid_o, 0);
    // A stalled grant holds when a request shows up ahead of it
    for (int k = 0; k < cc_pkg::NumAcc; k++) rsp[k].data = $urandom;
    @(negedge clk_i);
    for (int k = 0; k < cc_pkg::NumAcc; k++) acc_rsp_i[k] = rsp[k];
    acc_pvalid_i    = '0;
    acc_pvalid_i[2] = 1'b1;
    @(negedge clk_i);
    acc_pvalid_i[0] = 1'b1;
    acc_pvalid_i[3] = 1'b1;
    take_acc_rsp(2, rsp[2]);
    // Search resumes past index 2 and wraps around to 0
    take_acc_rsp(3, rsp[3]);
    take_acc_rsp(0, rsp[0]);
    #1;
    check_flags("acc_pvalid_o", acc_pvalid_o, 0);
  endtask

  task automatic test_decode();
    send_req(0, TcdmBase | ($urandom & 32'hffc), 1'b1, 1'b1);
    send_req(1, AliasBase | ($urandom & 32'hffc), 1'b1, 1'b1);
    send_req(0, SocBase | ($urandom & 32'hfffc), 1'b0, 1'b1);
    // First word past the TCDM window
    send_req(1, TcdmBase + 32'h1000, 1'b0, 1'b1);
    wait_drain();
  endtask

  task automatic test_ordered_return();
    fork
      run_requester(0);
      run_requester(1);
    join
    wait_drain();
  endtask

  task automatic test_capacity();
    cc_pkg::dreq_t req;
    cc_pkg::drsp_t exp;
    int unsigned   seen;
    int            cyc;
    reset_dut();
    mem_respond = 1'b0;
    for (int i = 0; i < RespDepth; i++) send_req(0, SocBase | 32'(i << 2), 1'b0, 1'b0);
    req.addr  = TcdmBase | 32'h40;
    req.data  = $urandom;
    req.strb  = 4'hf;
    req.write = 1'b0;
    exp.data  = req.addr ^ TcdmKey;
    exp.error = 1'b0;
    exp_q[0].push_back(exp);
    @(negedge clk_i);
    dreq_i[0]       = req;
    dreq_valid_i[0] = 1'b1;
    seen            = rsp_count;
    for (cyc = 0; cyc < Timeout; cyc++) begin
      @(posedge clk_i);
      if (dreq_ready_o[0]) break;
      @(negedge clk_i);
      // Targets start answering after a stretch with the FIFO full
      if (cyc == 8) mem_respond = 1'b1;
    end
    if (cyc == Timeout) report_failure("Timeout: request never accepted after FIFO drained");
    if (rsp_count == seen) report_failure("Request accepted while the order FIFO was full");
    @(negedge clk_i);
    dreq_valid_i[0] = 1'b0;
    wait_drain();
  endtask

  initial begin
    void'($urandom(48));
    rst_ni       = 1'b1;
    tcdm_base_i  = TcdmBase;
    acc_req_i    = '0;
    acc_qvalid_i = 1'b0;
    acc_qready_i = '0;
    acc_rsp_i    = '0;
    acc_pvalid_i = '0;
    acc_pready_i = 1'b0;
    dreq_i       = '0;
    dreq_valid_i = '0;
    drsp_ready_i = '1;
    tcdm_ready_i = 1'b1;
    soc_ready_i  = 1'b1;
    mem_respond  = 1'b1;
    reset_dut();
    test_offload_route();
    test_acc_arbitration();
    test_decode();
    test_ordered_return();
    test_capacity();
    if (u_dut.u_cc_sva.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      report_failure("Concurrent assertions failed during the run");
    end
  end

endmodule

// In-order target model with a random response delay of 0 to 3 cycles
module mem_model #(
  parameter logic [cc_pkg::DataWidth-1:0] Key = '0
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          respond_i,
  input  logic          req_valid_i,
  input  logic          req_ready_i,
  input  cc_pkg::dreq_t req_i,
  output cc_pkg::drsp_t rsp_o,
  output logic          rsp_valid_o,
  input  logic          rsp_ready_i
);

  logic [cc_pkg::AddrWidth-1:0] pend_q [$];
  int unsigned                  delay;
  bit                           fired;

  initial begin
    rsp_o       = '0;
    rsp_valid_o = 1'b0;
    delay       = 0;
    forever begin
      @(posedge clk_i);
      fired = rsp_valid_o && rsp_ready_i;
      if (rst_ni) begin
        pend_q.delete();
      end else begin
        if (req_valid_i && req_ready_i) pend_q.push_back(req_i.addr);
        if (fired) void'(pend_q.pop_front());
      end
      @(negedge clk_i);
      if (fired || rst_ni) begin
        rsp_valid_o = 1'b0;
        delay       = $urandom_range(3);
      end
      if (!rsp_valid_o && respond_i && pend_q.size() != 0) begin
        if (delay == 0) begin
          rsp_o.data  = pend_q[0] ^ Key;
          rsp_o.error = 1'b0;
          rsp_valid_o = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

// ==== compile.f ====
design/cc_pkg.sv
design/offload_demux.sv
design/rr_arbiter.sv
design/data_router.sv
design/core_complex.sv
bench/cc_sva.sv
bench/tb_core_complex.sv
